//--- common/fpc_defines.svh
`ifndef FPC_DEFINES_SVH
`define FPC_DEFINES_SVH

// each core owns half of the fingerprint RAM, so a pointer is one bit short of a RAM address
`define CRC_RAM_ADDRESS_WIDTH 9
`define CRC_KEY_WIDTH 4
`define CRC_KEY_SIZE 16
`define FPRINT_WIDTH 32

// APB register map
`define FPC_REG_REGION_EX 8'h00
`define FPC_REG_REGION_COMP 8'h04
`define FPC_REG_PTR_SET 8'h08
`define FPC_REG_TASK_RESET 8'h0C
`define FPC_REG_STATUS 8'h10
`define FPC_REG_READY 8'h14

`endif

//--- common/fpc_cfg_pkg.sv
`default_nettype none
`include "fpc_defines.svh"

package fpc_cfg_pkg;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// buffer region, start and end are both inclusive
	typedef struct packed {
		logic [31-2*`CRC_RAM_ADDRESS_WIDTH:0] pad;
		logic [`CRC_RAM_ADDRESS_WIDTH-1:0] end_ptr;
		logic [`CRC_RAM_ADDRESS_WIDTH-1:0] start_ptr;
	} region_view_t;

	typedef struct packed {
		logic [31-`CRC_KEY_WIDTH-`CRC_RAM_ADDRESS_WIDTH:0] pad;
		logic [`CRC_KEY_WIDTH-1:0] task_offset;
		logic [`CRC_RAM_ADDRESS_WIDTH-1:0] addr;
	} ptr_set_view_t;

	typedef union packed {
		region_view_t region;
		ptr_set_view_t ptr_set;
	} cfg_word_u;

endpackage

`default_nettype wire

//--- common/fpc_data_pkg.sv
`default_nettype none
`include "fpc_defines.svh"

package fpc_data_pkg;

	// one fingerprint from either core
	typedef struct packed {
		logic core_id;
		logic [`CRC_KEY_WIDTH-1:0] task_id;
		logic [`FPRINT_WIDTH-1:0] crc;
	} fprint_in_t;

	// the top address bit selects the core half of the RAM
	typedef struct packed {
		logic req;
		logic we;
		logic [`CRC_RAM_ADDRESS_WIDTH:0] addr;
		logic [`FPRINT_WIDTH-1:0] wdata;
	} store_req_t;

endpackage

`default_nettype wire

//--- verilog/fpc_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fpc_apb_regs (
	input wire clk,
	input wire reset,
	input wire fpc_cfg_pkg::apb_req_t apb,
	output logic [31:0] prdata,
	output logic pready,
	output fpc_cfg_pkg::cfg_word_u region_ex,
	output fpc_cfg_pkg::cfg_word_u region_comp,
	output logic set_head_tail,
	output fpc_cfg_pkg::cfg_word_u head_tail_word,
	input wire head_tail_ack,
	output logic task_reset_req,
	output logic [`CRC_KEY_WIDTH-1:0] task_reset_id,
	input wire reset_task,
	input wire mismatch,
	input wire [`CRC_KEY_WIDTH-1:0] mismatch_task,
	input wire [`CRC_KEY_SIZE-1:0] fprints_ready
);

	logic access;
	logic wr;
	fpc_cfg_pkg::cfg_word_u wword;

	assign access = apb.psel & apb.penable;
	assign wr = access & apb.pwrite;
	assign wword = apb.pwdata;

	// both commands stay up for the whole access phase, which holds them until their ack
	assign set_head_tail = wr & (apb.paddr == `FPC_REG_PTR_SET);
	assign head_tail_word = wword;
	assign task_reset_req = wr & (apb.paddr == `FPC_REG_TASK_RESET);
	assign task_reset_id = wword.ptr_set.task_offset; // task id sits in the same field as for PTR_SET

	assign pready = access & ~(set_head_tail & ~head_tail_ack) & ~(task_reset_req & ~reset_task);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			region_ex <= '0;
			region_comp <= '0;
		end else if (wr) begin
			case (apb.paddr)
				`FPC_REG_REGION_EX: region_ex <= wword;
				`FPC_REG_REGION_COMP: region_comp <= wword;
				default: ;
			endcase
		end
	end

	always_comb begin
		prdata = '0;
		if (access && !apb.pwrite) begin
			case (apb.paddr)
				`FPC_REG_REGION_EX: prdata = region_ex;
				`FPC_REG_REGION_COMP: prdata = region_comp;
				`FPC_REG_STATUS: prdata = {{(31-`CRC_KEY_WIDTH){1'b0}}, mismatch_task, mismatch};
				`FPC_REG_READY: prdata = {{(32-`CRC_KEY_SIZE){1'b0}}, fprints_ready};
				default: prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- comp_registers/comp_registers.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module comp_registers (
	input wire clk,
	input wire reset,

	// pointer load from the APB side
	input wire fpc_cfg_pkg::cfg_word_u head_tail_word,
	input wire set_head_tail,
	output logic head_tail_ack,

	// head pointer lookup for the writer
	input wire logical_core_id,
	input wire [`CRC_KEY_WIDTH-1:0] fprint_task_id,
	output logic [`CRC_RAM_ADDRESS_WIDTH-1:0] fprint_head_pointer,
	input wire increment_head_pointer,
	output logic increment_hp_ack,

	input wire fpc_cfg_pkg::cfg_word_u region_ex,
	input wire fpc_cfg_pkg::cfg_word_u region_comp,

	// comparator side
	input wire [`CRC_KEY_WIDTH-1:0] comp_task,
	output logic [`CRC_KEY_SIZE-1:0] fprints_ready_out,
	output logic head0_matches_head1,
	output logic tail0_matches_head0,
	output logic tail1_matches_head1,
	output logic [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer0,
	output logic [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer1,
	input wire comp_increment_tail_pointer,
	input wire comp_reset_fprint_ready,
	output logic reset_fprint_ack,
	input wire comp_reset_task,
	output logic reset_task
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SET,
		ST_SET_ACK,
		ST_INC_ACK,
		ST_CLR_READY,
		ST_RESET_TASK
	} state_t;

	state_t state;

	// tables are indexed [core][task]
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] head_mem [2][`CRC_KEY_SIZE];
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] tail_mem [2][`CRC_KEY_SIZE];

	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] head_rd_fp [2];	// at fprint_task_id
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] head_rd_cmp [2];	// at comp_task
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] tail_rd [2];		// at comp_task
	logic [1:0][`CRC_KEY_SIZE-1:0] ready_bits;

	function automatic logic [`CRC_RAM_ADDRESS_WIDTH-1:0] wrap_inc(
		input logic [`CRC_RAM_ADDRESS_WIDTH-1:0] ptr,
		input fpc_cfg_pkg::cfg_word_u region
	);
		return (ptr == region.region.end_ptr) ? region.region.start_ptr : ptr + 1'b1;
	endfunction

	// one request at a time, so the command sources never see an ack meant for another
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (set_head_tail)
						state <= ST_SET;
					else if (increment_head_pointer)
						state <= ST_INC_ACK;
					else if (comp_reset_fprint_ready)
						state <= ST_CLR_READY;
					else if (comp_reset_task)
						state <= ST_RESET_TASK;
				end
				ST_SET: state <= ST_SET_ACK;
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign head_tail_ack = (state == ST_SET_ACK);
	assign increment_hp_ack = (state == ST_INC_ACK);
	assign reset_fprint_ack = (state == ST_CLR_READY);
	assign reset_task = (state == ST_RESET_TASK);

	// pointer tables; reads return the entry at the index seen on the previous clock
	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (state == ST_SET)
				head_mem[c][head_tail_word.ptr_set.task_offset] <= head_tail_word.ptr_set.addr;
			else if (increment_hp_ack && logical_core_id == 1'(c))
				head_mem[c][fprint_task_id] <= wrap_inc(head_rd_fp[c], region_ex);
			else if (reset_task)
				head_mem[c][comp_task] <= region_ex.region.start_ptr;

			if (state == ST_SET)
				tail_mem[c][head_tail_word.ptr_set.task_offset] <= head_tail_word.ptr_set.addr;
			else if (comp_increment_tail_pointer)	// both tails move together
				tail_mem[c][comp_task] <= wrap_inc(tail_rd[c], region_comp);
			else if (reset_task)
				tail_mem[c][comp_task] <= region_comp.region.start_ptr;

			head_rd_fp[c] <= head_mem[c][fprint_task_id];
			head_rd_cmp[c] <= head_mem[c][comp_task];
			tail_rd[c] <= tail_mem[c][comp_task];
		end
	end

	assign fprint_head_pointer = head_rd_fp[logical_core_id];
	assign comp_tail_pointer0 = tail_rd[0];
	assign comp_tail_pointer1 = tail_rd[1];

	assign head0_matches_head1 = (head_rd_cmp[0] == head_rd_cmp[1]);
	assign tail0_matches_head0 = (tail_rd[0] == head_rd_cmp[0]);
	assign tail1_matches_head1 = (tail_rd[1] == head_rd_cmp[1]);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ready_bits <= '0;
		end else if (increment_hp_ack) begin
			ready_bits[logical_core_id][fprint_task_id] <= 1'b1;
		end else if (reset_task) begin
			ready_bits[0][comp_task] <= 1'b0;
			ready_bits[1][comp_task] <= 1'b0;
		end else if (reset_fprint_ack) begin
			// a core stays ready while it still has unread fingerprints
			if (tail0_matches_head0)
				ready_bits[0][comp_task] <= 1'b0;
			if (tail1_matches_head1)
				ready_bits[1][comp_task] <= 1'b0;
		end
	end

	assign fprints_ready_out = ready_bits[0] & ready_bits[1];

endmodule

`default_nettype wire

//--- verilog/fprint_writer.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fprint_writer (
	input wire clk,
	input wire reset,
	input wire fpc_data_pkg::fprint_in_t fprint_in,
	input wire fprint_valid,
	output logic fprint_ready,
	output logic logical_core_id,
	output logic [`CRC_KEY_WIDTH-1:0] fprint_task_id,
	input wire [`CRC_RAM_ADDRESS_WIDTH-1:0] fprint_head_pointer,
	output fpc_data_pkg::store_req_t store_req,
	input wire store_gnt,
	output logic increment_head_pointer,
	input wire increment_hp_ack
);

	typedef enum logic [1:0] {W_IDLE, W_HP_READ, W_WRITE, W_INC} state_t;

	state_t state;
	fpc_data_pkg::fprint_in_t fp;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= W_IDLE;
		end else begin
			case (state)
				W_IDLE: if (fprint_valid) state <= W_HP_READ;
				W_HP_READ: state <= W_WRITE;	// registered head pointer lookup
				W_WRITE: if (store_gnt) state <= W_INC;
				W_INC: if (increment_hp_ack) state <= W_IDLE;
				default: state <= W_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fprint_valid && fprint_ready)
			fp <= fprint_in;
	end

	assign fprint_ready = (state == W_IDLE);
	assign logical_core_id = fp.core_id;
	assign fprint_task_id = fp.task_id;

	assign store_req.req = (state == W_WRITE);
	assign store_req.we = 1'b1;
	assign store_req.addr = {fp.core_id, fprint_head_pointer};
	assign store_req.wdata = fp.crc;

	assign increment_head_pointer = (state == W_INC);

endmodule

`default_nettype wire

//--- verilog/fprint_comparator.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fprint_comparator (
	input wire clk,
	input wire reset,
	output logic [`CRC_KEY_WIDTH-1:0] comp_task,
	input wire [`CRC_KEY_SIZE-1:0] fprints_ready_out,
	input wire tail0_matches_head0,
	input wire tail1_matches_head1,
	input wire [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer0,
	input wire [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer1,
	output fpc_data_pkg::store_req_t store_req,
	input wire store_gnt,
	input wire store_rvalid,
	input wire [`FPRINT_WIDTH-1:0] store_rdata,
	output logic comp_increment_tail_pointer,
	output logic comp_reset_fprint_ready,
	input wire reset_fprint_ack,
	input wire task_reset_req,
	input wire [`CRC_KEY_WIDTH-1:0] task_reset_id,
	output logic comp_reset_task,
	input wire reset_task,
	output logic mismatch,
	output logic [`CRC_KEY_WIDTH-1:0] mismatch_task
);

	typedef enum logic [3:0] {
		C_IDLE, C_INDEX, C_CHECK, C_RD0, C_WAIT0, C_RD1, C_WAIT1, C_CMP, C_INC, C_CLR, C_RESET
	} state_t;

	state_t state;
	logic [`FPRINT_WIDTH-1:0] fp0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= C_IDLE;
			comp_task <= '0;
			mismatch <= 1'b0;
			mismatch_task <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (task_reset_req) begin
						comp_task <= task_reset_id;
						state <= C_RESET;
					end else begin
						comp_task <= comp_task + 1'b1;
						state <= C_INDEX;
					end
				end
				C_INDEX: state <= C_CHECK;	// pointer tables return the new index here
				C_CHECK: begin
					if (fprints_ready_out[comp_task] && !tail0_matches_head0 && !tail1_matches_head1)
						state <= C_RD0;
					else
						state <= C_IDLE;
				end
				C_RD0: if (store_gnt) state <= C_WAIT0;
				C_WAIT0: if (store_rvalid) state <= C_RD1;
				C_RD1: if (store_gnt) state <= C_WAIT1;
				C_WAIT1: if (store_rvalid) state <= C_CMP;
				C_CMP: begin
					// keep the first failing task only
					if (fp0 != store_rdata && !mismatch) begin
						mismatch <= 1'b1;
						mismatch_task <= comp_task;
					end
					state <= C_INC;
				end
				C_INC: state <= C_CLR;
				C_CLR: if (reset_fprint_ack) state <= C_IDLE;
				C_RESET: if (reset_task) state <= C_IDLE;
				default: state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == C_WAIT0 && store_rvalid)
			fp0 <= store_rdata;
	end

	// core 1's word stays on store_rdata until the next comparator read
	assign store_req.req = (state == C_RD0) || (state == C_RD1);
	assign store_req.we = 1'b0;
	assign store_req.addr = (state == C_RD1) ? {1'b1, comp_tail_pointer1}
		: {1'b0, comp_tail_pointer0};
	assign store_req.wdata = '0;

	assign comp_increment_tail_pointer = (state == C_INC);
	assign comp_reset_fprint_ready = (state == C_CLR);
	assign comp_reset_task = (state == C_RESET);

endmodule

`default_nettype wire

//--- verilog/fprint_store.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fprint_store (
	input wire clk,
	input wire reset,
	input wire fpc_data_pkg::store_req_t wr_req,
	input wire fpc_data_pkg::store_req_t cmp_req,
	output logic wr_gnt,
	output logic cmp_gnt,
	output logic cmp_rvalid,
	output logic [`FPRINT_WIDTH-1:0] rdata
);

	localparam int DEPTH = 1 << (`CRC_RAM_ADDRESS_WIDTH + 1);

	logic [`FPRINT_WIDTH-1:0] mem [DEPTH];
	logic last_cmp;	// comparator won the last grant
	fpc_data_pkg::store_req_t sel;

	// round robin, the loser of the last grant wins a tie
	assign wr_gnt = wr_req.req & (~cmp_req.req | last_cmp);
	assign cmp_gnt = cmp_req.req & (~wr_req.req | ~last_cmp);
	assign sel = cmp_gnt ? cmp_req : wr_req;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			last_cmp <= 1'b0;
			cmp_rvalid <= 1'b0;
		end else begin
			if (wr_gnt || cmp_gnt)
				last_cmp <= cmp_gnt;
			cmp_rvalid <= cmp_gnt & ~cmp_req.we;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_gnt || cmp_gnt) begin
			if (sel.we)
				mem[sel.addr] <= sel.wdata;
			else
				rdata <= mem[sel.addr];	// held until the next granted read
		end
	end

endmodule

`default_nettype wire

//--- verilog/fpc_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fpc_top (
	input wire clk,
	input wire reset,
	input wire fpc_cfg_pkg::apb_req_t apb,
	output wire [31:0] prdata,
	output wire pready,
	input wire fpc_data_pkg::fprint_in_t fprint_in,
	input wire fprint_valid,
	output wire fprint_ready,
	output wire mismatch
);

	fpc_cfg_pkg::cfg_word_u region_ex;
	fpc_cfg_pkg::cfg_word_u region_comp;
	fpc_cfg_pkg::cfg_word_u head_tail_word;
	logic set_head_tail;
	logic head_tail_ack;
	logic task_reset_req;
	logic [`CRC_KEY_WIDTH-1:0] task_reset_id;
	logic reset_task;
	logic [`CRC_KEY_WIDTH-1:0] mismatch_task;
	logic [`CRC_KEY_SIZE-1:0] fprints_ready_out;

	logic logical_core_id;
	logic [`CRC_KEY_WIDTH-1:0] fprint_task_id;
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] fprint_head_pointer;
	logic increment_head_pointer;
	logic increment_hp_ack;

	logic [`CRC_KEY_WIDTH-1:0] comp_task;
	logic tail0_matches_head0;
	logic tail1_matches_head1;
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer0;
	logic [`CRC_RAM_ADDRESS_WIDTH-1:0] comp_tail_pointer1;
	logic comp_increment_tail_pointer;
	logic comp_reset_fprint_ready;
	logic reset_fprint_ack;
	logic comp_reset_task;

	fpc_data_pkg::store_req_t wr_req;
	fpc_data_pkg::store_req_t cmp_req;
	logic wr_gnt;
	logic cmp_gnt;
	logic cmp_rvalid;
	logic [`FPRINT_WIDTH-1:0] store_rdata;

	fpc_apb_regs u_apb_regs (
		.clk(clk),
		.reset(reset),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.region_ex(region_ex),
		.region_comp(region_comp),
		.set_head_tail(set_head_tail),
		.head_tail_word(head_tail_word),
		.head_tail_ack(head_tail_ack),
		.task_reset_req(task_reset_req),
		.task_reset_id(task_reset_id),
		.reset_task(reset_task),
		.mismatch(mismatch),
		.mismatch_task(mismatch_task),
		.fprints_ready(fprints_ready_out)
	);

	comp_registers u_comp_registers (
		.clk(clk),
		.reset(reset),
		.head_tail_word(head_tail_word),
		.set_head_tail(set_head_tail),
		.head_tail_ack(head_tail_ack),
		.logical_core_id(logical_core_id),
		.fprint_task_id(fprint_task_id),
		.fprint_head_pointer(fprint_head_pointer),
		.increment_head_pointer(increment_head_pointer),
		.increment_hp_ack(increment_hp_ack),
		.region_ex(region_ex),
		.region_comp(region_comp),
		.comp_task(comp_task),
		.fprints_ready_out(fprints_ready_out),
		.head0_matches_head1(),	// status only, nothing consumes it here
		.tail0_matches_head0(tail0_matches_head0),
		.tail1_matches_head1(tail1_matches_head1),
		.comp_tail_pointer0(comp_tail_pointer0),
		.comp_tail_pointer1(comp_tail_pointer1),
		.comp_increment_tail_pointer(comp_increment_tail_pointer),
		.comp_reset_fprint_ready(comp_reset_fprint_ready),
		.reset_fprint_ack(reset_fprint_ack),
		.comp_reset_task(comp_reset_task),
		.reset_task(reset_task)
	);

	fprint_writer u_writer (
		.clk(clk),
		.reset(reset),
		.fprint_in(fprint_in),
		.fprint_valid(fprint_valid),
		.fprint_ready(fprint_ready),
		.logical_core_id(logical_core_id),
		.fprint_task_id(fprint_task_id),
		.fprint_head_pointer(fprint_head_pointer),
		.store_req(wr_req),
		.store_gnt(wr_gnt),
		.increment_head_pointer(increment_head_pointer),
		.increment_hp_ack(increment_hp_ack)
	);

	fprint_comparator u_comparator (
		.clk(clk),
		.reset(reset),
		.comp_task(comp_task),
		.fprints_ready_out(fprints_ready_out),
		.tail0_matches_head0(tail0_matches_head0),
		.tail1_matches_head1(tail1_matches_head1),
		.comp_tail_pointer0(comp_tail_pointer0),
		.comp_tail_pointer1(comp_tail_pointer1),
		.store_req(cmp_req),
		.store_gnt(cmp_gnt),
		.store_rvalid(cmp_rvalid),
		.store_rdata(store_rdata),
		.comp_increment_tail_pointer(comp_increment_tail_pointer),
		.comp_reset_fprint_ready(comp_reset_fprint_ready),
		.reset_fprint_ack(reset_fprint_ack),
		.task_reset_req(task_reset_req),
		.task_reset_id(task_reset_id),
		.comp_reset_task(comp_reset_task),
		.reset_task(reset_task),
		.mismatch(mismatch),
		.mismatch_task(mismatch_task)
	);

	fprint_store u_store (
		.clk(clk),
		.reset(reset),
		.wr_req(wr_req),
		.cmp_req(cmp_req),
		.wr_gnt(wr_gnt),
		.cmp_gnt(cmp_gnt),
		.cmp_rvalid(cmp_rvalid),
		.rdata(store_rdata)
	);

endmodule

`default_nettype wire

//--- sim/fpc_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fpc_checker (
	input wire clk,
	input wire reset,
	input wire set_head_tail,
	input wire head_tail_ack,
	input wire increment_head_pointer,
	input wire increment_hp_ack,
	input wire comp_reset_fprint_ready,
	input wire reset_fprint_ack,
	input wire comp_reset_task,
	input wire reset_task
);

	// the writer still holds its request when the head increment is acked
	a_inc_ack: assert property (@(posedge clk) disable iff (reset)
		increment_hp_ack |-> increment_head_pointer)
		else $error("head increment ack without a pending request");

	a_inc_hold: assert property (@(posedge clk) disable iff (reset)
		increment_head_pointer && !increment_hp_ack |=> increment_head_pointer)
		else $error("head increment request dropped before its ack");

	a_clr_hold: assert property (@(posedge clk) disable iff (reset)
		comp_reset_fprint_ready && !reset_fprint_ack |=> comp_reset_fprint_ready)
		else $error("ready clear request dropped before its ack");

	a_task_reset_hold: assert property (@(posedge clk) disable iff (reset)
		comp_reset_task && !reset_task |=> comp_reset_task)
		else $error("task reset request dropped before its ack");

	a_set_ack: assert property (@(posedge clk) disable iff (reset)
		head_tail_ack |-> set_head_tail)
		else $error("pointer set ack without a pending request");

endmodule

`default_nettype wire

//--- sim/fpc_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module fpc_monitor (
	input wire clk,
	input wire fpc_cfg_pkg::apb_req_t apb,
	input wire [31:0] prdata,
	input wire pready,
	input wire mismatch
);

	string test_name;
	int test_errors;
	int errors;
	int tests_run;
	int tests_failed;
	logic [31:0] last_rdata;

	initial begin
		test_errors = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		last_rdata = '0;
	end

	// sampled after the falling edge, once the stimulus has settled
	always @(negedge clk) begin
		#2;
		if (apb.psel && apb.penable && pready && !apb.pwrite)
			last_rdata = prdata;
	end

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic check_read(input logic [31:0] expected);
		if (last_rdata !== expected) begin
			$display("error %s: expected %h actual %h", test_name, expected, last_rdata);
			test_errors++;
		end
	endtask

	task automatic check_mismatch(input logic expected);
		if (mismatch !== expected) begin
			$display("error %s: expected %b actual %b", test_name, expected, mismatch); // mismatch pin
			test_errors++;
		end
	endtask

	task automatic finish_test();
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", test_name, test_errors);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	task automatic report();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
	endtask

endmodule

`default_nettype wire

//--- sim/fpc_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "fpc_defines.svh"

module fpc_tb;

	// fingerprints sent in all tests together sets the run limit
	localparam int NUM_FPRINTS = 58;
	localparam int CYCLE_LIMIT = 200 * NUM_FPRINTS + 2000;

	logic clk;
	logic reset;
	fpc_cfg_pkg::apb_req_t apb;
	logic [31:0] prdata;
	logic pready;
	fpc_data_pkg::fprint_in_t fprint_in;
	logic fprint_valid;
	logic fprint_ready;
	logic mismatch;

	integer seed;
	int cycles;
	logic [31:0] sent0 [16][$];	// per task, in the order sent
	logic [31:0] sent1 [16][$];

	fpc_top dut0 (
		.clk(clk),
		.reset(reset),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.fprint_in(fprint_in),
		.fprint_valid(fprint_valid),
		.fprint_ready(fprint_ready),
		.mismatch(mismatch)
	);

	fpc_monitor mon0 (
		.clk(clk),
		.apb(apb),
		.prdata(prdata),
		.pready(pready),
		.mismatch(mismatch)
	);

	bind comp_registers fpc_checker chk0 (
		.clk(clk),
		.reset(reset),
		.set_head_tail(set_head_tail),
		.head_tail_ack(head_tail_ack),
		.increment_head_pointer(increment_head_pointer),
		.increment_hp_ack(increment_hp_ack),
		.comp_reset_fprint_ready(comp_reset_fprint_ready),
		.reset_fprint_ack(reset_fprint_ack),
		.comp_reset_task(comp_reset_task),
		.reset_task(reset_task)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// flag in bit 4, first differing task below it
	function automatic logic [4:0] fpc_expect();
		int n;
		for (int t = 0; t < 16; t++) begin
			n = (sent0[t].size() < sent1[t].size()) ? sent0[t].size() : sent1[t].size();
			for (int i = 0; i < n; i++)
				if (sent0[t][i] != sent1[t][i])
					return {1'b1, 4'(t)};
		end
		return 5'b0;
	endfunction

	function automatic logic [31:0] status_word(input logic [4:0] e);
		return e[4] ? {27'b0, e[3:0], 1'b1} : 32'h0;
	endfunction

	task automatic clear_sent();
		for (int t = 0; t < 16; t++) begin
			sent0[t].delete();
			sent1[t].delete();
		end
	endtask

	task automatic reset_dut();
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rdata);
		@(negedge clk);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = wr;
		apb.paddr = addr;
		apb.pwdata = data;
		@(negedge clk);
		apb.penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		@(negedge clk);	// the access completed on the rising edge in between
		apb = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rd;
		apb_access(1'b0, addr, 32'h0, rd);
		mon0.check_read(expected);
	endtask

	task automatic set_region(input int start_ptr, input int end_ptr);
		fpc_cfg_pkg::cfg_word_u w;
		w = '0;
		w.region.start_ptr = start_ptr[8:0];
		w.region.end_ptr = end_ptr[8:0];
		apb_write(`FPC_REG_REGION_EX, w);
		apb_write(`FPC_REG_REGION_COMP, w);
	endtask

	task automatic set_pointers(input int tid, input int addr);
		fpc_cfg_pkg::cfg_word_u w;
		w = '0;
		w.ptr_set.task_offset = tid[3:0];
		w.ptr_set.addr = addr[8:0];
		apb_write(`FPC_REG_PTR_SET, w);
	endtask

	task automatic send_fprint(input logic core, input int tid, input logic [31:0] crc);
		@(negedge clk);
		fprint_in.core_id = core;
		fprint_in.task_id = tid[3:0];
		fprint_in.crc = crc;
		fprint_valid = 1'b1;
		#1;
		while (!fprint_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		fprint_valid = 1'b0;
		#1;
		// writer is back in idle once the head has advanced
		while (!fprint_ready) begin
			@(negedge clk);
			#1;
		end
		if (core)
			sent1[tid].push_back(crc);
		else
			sent0[tid].push_back(crc);
	endtask

	task automatic wait_drain(input int tid);
		logic [31:0] rd;
		apb_access(1'b0, `FPC_REG_READY, 32'h0, rd);
		while (rd[tid]) begin
			apb_access(1'b0, `FPC_REG_READY, 32'h0, rd);
		end
	endtask

	task automatic send_pair(input int tid, input logic [31:0] crc0, input logic [31:0] crc1);
		send_fprint(1'b0, tid, crc0);
		send_fprint(1'b1, tid, crc1);
		wait_drain(tid);
	endtask

	initial begin
		logic [31:0] r;
		logic [4:0] e;
		fpc_cfg_pkg::cfg_word_u w;
		clk = 1'b0;
		reset = 1'b1;
		apb = '0;
		fprint_in = '0;
		fprint_valid = 1'b0;
		cycles = 0;
		seed = 32'h981d_7e60;
		reset_dut();

		mon0.start_test("reset_state");
		read_check(`FPC_REG_STATUS, 32'h0);
		read_check(`FPC_REG_READY, 32'h0);
		mon0.check_mismatch(1'b0);
		mon0.finish_test();

		mon0.start_test("region_config");
		set_region(0, 255);
		w = '0;
		w.region.start_ptr = 9'd0;
		w.region.end_ptr = 9'd255;
		read_check(`FPC_REG_REGION_EX, w);
		read_check(`FPC_REG_REGION_COMP, w);
		for (int t = 1; t <= 5; t++)
			set_pointers(t, 16 * t);	// returns only once pready has come back
		mon0.finish_test();

		mon0.start_test("matching_random");
		clear_sent();
		for (int t = 1; t <= 3; t++) begin
			for (int k = 0; k < 4; k++) begin
				r = $random(seed);
				send_pair(t, r, r);
			end
		end
		e = fpc_expect();
		read_check(`FPC_REG_READY, 32'h0);
		read_check(`FPC_REG_STATUS, status_word(e));
		mon0.check_mismatch(e[4]);
		mon0.finish_test();

		mon0.start_test("single_mismatch");
		clear_sent();
		for (int k = 0; k < 3; k++) begin
			r = $random(seed);
			send_pair(5, r, (k == 1) ? r ^ 32'h1 : r);
		end
		e = fpc_expect();
		read_check(`FPC_REG_STATUS, status_word(e));
		mon0.check_mismatch(e[4]);
		mon0.finish_test();

		// mismatch is sticky, so the remaining tests start from a fresh reset
		reset_dut();
		mon0.start_test("pointer_wrap");
		clear_sent();
		set_region(100, 103);
		set_pointers(7, 100);
		for (int k = 0; k < 10; k++) begin
			r = $random(seed);
			send_pair(7, r, r);
		end
		e = fpc_expect();
		read_check(`FPC_REG_READY, 32'h0);
		read_check(`FPC_REG_STATUS, status_word(e));
		mon0.check_mismatch(e[4]);
		mon0.finish_test();

		mon0.start_test("task_reset");
		clear_sent();
		set_pointers(9, 100);
		// four per core fill the region so each head lands back on its tail
		for (int k = 0; k < 4; k++)
			send_fprint(1'b0, 9, $random(seed));
		for (int k = 0; k < 4; k++)
			send_fprint(1'b1, 9, $random(seed));
		read_check(`FPC_REG_READY, 32'h1 << 9);
		w = '0;
		w.ptr_set.task_offset = 4'd9;
		apb_write(`FPC_REG_TASK_RESET, w);
		read_check(`FPC_REG_READY, 32'h0);
		mon0.finish_test();

		mon0.report();
		if (mon0.errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/fpc_cfg_pkg.sv
common/fpc_data_pkg.sv
verilog/fpc_apb_regs.sv
comp_registers/comp_registers.sv
verilog/fprint_writer.sv
verilog/fprint_comparator.sv
verilog/fprint_store.sv
verilog/fpc_top.sv
sim/fpc_checker.sv
sim/fpc_monitor.sv
sim/fpc_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module fpc_tb -o fpc_sim
out=$(./obj_dir/fpc_sim)
echo "$out"
echo "$out" | grep -qx "test passed"
